// File: sdram_pkg.sv
package sdram_pkg;

    // SDRAM command patterns as {cs_n, ras_n, cas_n, we_n}
    localparam logic [3:0] cmd_nop       = 4'b0111;
    localparam logic [3:0] cmd_precharge = 4'b0010;
    localparam logic [3:0] cmd_refresh   = 4'b0001; // Auto refresh
    localparam logic [3:0] cmd_mrs       = 4'b0000; // Mode register set
    localparam logic [3:0] cmd_deselect  = 4'b1111; // Chip not selected

    localparam int addr_w     = 13; // Row/column address pins
    localparam int ba_w       = 2;  // Bank address pins
    localparam int cfg_addr_w = 2;
    localparam int cfg_data_w = 16;
    localparam int cas_w      = 2;  // CAS latency field
    localparam int burst_w    = 3;  // Burst length code

    // Configuration register map
    localparam logic [cfg_addr_w-1:0] cfg_powerup = 2'd0;
    localparam logic [cfg_addr_w-1:0] cfg_mode    = 2'd1; // CAS in 5:4, burst in 2:0
    localparam logic [cfg_addr_w-1:0] cfg_refi    = 2'd2;

    // Init timing in clock cycles at 200 MHz
    localparam int trp_cycles     = 2; // NOPs after PRECHARGE ALL
    localparam int trc_cycles     = 9; // NOPs after each init refresh
    localparam int init_refreshes = 8;
    localparam int init_ref_w     = $clog2(init_refreshes + 1);

    localparam int powerup_w = 15; // Power-up wait width
    localparam int refi_w    = 12; // Refresh interval width

    // Reset values of the configuration registers
    localparam logic [powerup_w-1:0] powerup_default = 15'd20000; // 100 us
    localparam logic [cas_w-1:0]     cas_default     = 2'd3;
    localparam logic [burst_w-1:0]   burst_default   = 3'd0;      // Single location
    localparam logic [refi_w-1:0]    refi_default    = 12'd1560;  // About 7.8 us

    // Mode register field positions, shared with the cfg_mode layout
    localparam int mrs_write_single_bit = 9;
    localparam int mrs_cas_lsb          = 4;
    localparam int mrs_burst_lsb        = 0;

    typedef logic [powerup_w-1:0]  gap_t;     // Init gap counter
    typedef logic [init_ref_w-1:0] ref_cnt_t; // Init refresh counter

endpackage

// File: sdram_cfg_regs.sv
`timescale 1ns/100ps

module sdram_cfg_regs (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             cfg_write,        // One-cycle write strobe
    input  logic [sdram_pkg::cfg_addr_w-1:0] cfg_addr,
    input  logic [sdram_pkg::cfg_data_w-1:0] cfg_data,
    input  logic                             busy,             // Init in progress
    output logic [sdram_pkg::powerup_w-1:0]  powerup_wait,
    output logic [sdram_pkg::cas_w-1:0]      cas_latency,
    output logic [sdram_pkg::burst_w-1:0]    burst_code,
    output logic [sdram_pkg::refi_w-1:0]     refresh_interval
);

    logic write_ok; // Write allowed this cycle

    // Frozen while the init sequence runs
    assign write_ok = cfg_write && !busy;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            powerup_wait     <= sdram_pkg::powerup_default;
            cas_latency      <= sdram_pkg::cas_default;
            burst_code       <= sdram_pkg::burst_default;
            refresh_interval <= sdram_pkg::refi_default;
        end else if (write_ok) begin
            case (cfg_addr)
                sdram_pkg::cfg_powerup: begin
                    powerup_wait <= cfg_data[sdram_pkg::powerup_w-1:0]; // Low bits only
                end
                sdram_pkg::cfg_mode: begin
                    // Same field layout as the mode register
                    cas_latency <= cfg_data[sdram_pkg::mrs_cas_lsb +: sdram_pkg::cas_w];
                    burst_code  <= cfg_data[sdram_pkg::mrs_burst_lsb +: sdram_pkg::burst_w];
                end
                sdram_pkg::cfg_refi: begin
                    refresh_interval <= cfg_data[sdram_pkg::refi_w-1:0];
                end
                default: ; // Address 3 is unmapped
            endcase
        end
    end

endmodule

// File: sdram_init.sv
`timescale 1ns/100ps

module sdram_init (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            start,        // Sampled in idle only
    input  logic [sdram_pkg::powerup_w-1:0] powerup_wait,
    input  logic [sdram_pkg::cas_w-1:0]     cas_latency,
    input  logic [sdram_pkg::burst_w-1:0]   burst_code,
    output logic                            busy,         // High from power-up through MRS
    output logic                            init_done,    // Pulse on the MRS cycle
    output logic [3:0]                      init_cmd,     // {cs_n, ras_n, cas_n, we_n}
    output logic [sdram_pkg::addr_w-1:0]    init_addr
);

    typedef enum logic [2:0] {
        st_idle,
        st_power_up,
        st_precharge,        // PRECHARGE ALL, one cycle
        st_precharge_wait,   // tRP gap
        st_refresh,          // One AUTO REFRESH
        st_refresh_wait,     // tRC gap
        st_mode_set          // MRS, one cycle
    } state_t;

    state_t               state;
    sdram_pkg::gap_t      gap_cnt;  // Counts down remaining NOP cycles
    sdram_pkg::ref_cnt_t  ref_cnt;  // Refreshes issued so far
    logic                 gap_end;  // Last NOP of a gap

    assign gap_end = (gap_cnt == '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= st_idle;
            gap_cnt <= '0;
            ref_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state   <= st_power_up;
                        gap_cnt <= powerup_wait - 1'b1; // Wait length read live
                    end
                end
                st_power_up: begin
                    if (gap_end) state <= st_precharge;
                    else         gap_cnt <= gap_cnt - 1'b1;
                end
                st_precharge: begin
                    state   <= st_precharge_wait;
                    gap_cnt <= sdram_pkg::gap_t'(sdram_pkg::trp_cycles - 1);
                    ref_cnt <= '0;                       // Fresh refresh count
                end
                st_precharge_wait: begin
                    if (gap_end) state <= st_refresh;
                    else         gap_cnt <= gap_cnt - 1'b1;
                end
                st_refresh: begin
                    state   <= st_refresh_wait;
                    gap_cnt <= sdram_pkg::gap_t'(sdram_pkg::trc_cycles - 1);
                    ref_cnt <= ref_cnt + 1'b1;
                end
                st_refresh_wait: begin
                    if (!gap_end) begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end else if (ref_cnt ==
                                 sdram_pkg::ref_cnt_t'(sdram_pkg::init_refreshes)) begin
                        state <= st_mode_set;            // All refreshes done
                    end else begin
                        state <= st_refresh;
                    end
                end
                st_mode_set: state <= st_idle;           // tMRD covered by idle
                default:     state <= st_idle;
            endcase
        end
    end

    // Command and address decode from state
    always_comb begin
        busy      = (state != st_idle);
        init_done = 1'b0;
        init_cmd  = sdram_pkg::cmd_nop;
        init_addr = '0;                                  // Don't care except PALL and MRS
        case (state)
            st_precharge: begin
                init_cmd      = sdram_pkg::cmd_precharge;
                init_addr[10] = 1'b1;                    // A10 selects all banks
            end
            st_refresh: begin
                init_cmd = sdram_pkg::cmd_refresh;
            end
            st_mode_set: begin
                init_cmd  = sdram_pkg::cmd_mrs;
                init_done = 1'b1;
                // Sequential burst, standard operation, reserved bits zero
                init_addr[sdram_pkg::mrs_write_single_bit]                  = 1'b1;
                init_addr[sdram_pkg::mrs_cas_lsb +: sdram_pkg::cas_w]       = cas_latency;
                init_addr[sdram_pkg::mrs_burst_lsb +: sdram_pkg::burst_w]   = burst_code;
            end
            default: begin
                init_cmd = sdram_pkg::cmd_nop;           // Idle and all gaps
            end
        endcase
    end

endmodule

// File: sdram_refresh.sv
`timescale 1ns/100ps

module sdram_refresh (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         init_done,        // MRS cycle of init
    input  logic                         busy,             // Init running
    input  logic [sdram_pkg::refi_w-1:0] refresh_interval,
    output logic                         ready,            // Memory usable
    output logic [3:0]                   ref_cmd           // {cs_n, ras_n, cas_n, we_n}
);

    logic [sdram_pkg::refi_w-1:0] interval_cnt; // Cycles since last restart
    logic                         refresh_due;

    // Due once the count reaches the interval
    assign refresh_due = ready && (interval_cnt == refresh_interval);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ready <= 1'b0;
        end else if (init_done) begin
            ready <= 1'b1;                         // Init finishing this cycle
        end else if (busy) begin
            ready <= 1'b0;                         // New init started
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            interval_cnt <= '0;
        end else if (init_done || refresh_due) begin
            interval_cnt <= sdram_pkg::refi_w'(1); // One cycle already elapsed next edge
        end else if (ready) begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    // Deselect until init has completed
    always_comb begin
        if (!ready) begin
            ref_cmd = sdram_pkg::cmd_deselect;
        end else if (refresh_due) begin
            ref_cmd = sdram_pkg::cmd_refresh;
        end else begin
            ref_cmd = sdram_pkg::cmd_nop;
        end
    end

endmodule

// File: sdram_cmd_out.sv
`timescale 1ns/100ps

module sdram_cmd_out (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         busy,       // Init owns the pins
    input  logic [3:0]                   init_cmd,
    input  logic [sdram_pkg::addr_w-1:0] init_addr,
    input  logic [3:0]                   ref_cmd,    // Refresh engine command
    output logic [sdram_pkg::addr_w-1:0] dram_addr,
    output logic [sdram_pkg::ba_w-1:0]   dram_ba,
    output logic                         dram_cs_n,
    output logic                         dram_ras_n,
    output logic                         dram_cas_n,
    output logic                         dram_we_n
);

    logic [3:0]                   next_cmd;
    logic [sdram_pkg::addr_w-1:0] next_addr;

    // Owner select, refresh commands carry no address
    assign next_cmd  = busy ? init_cmd  : ref_cmd;
    assign next_addr = busy ? init_addr : '0;

    assign dram_ba = '0; // Only bank 0 is used

    // Pin registers, one cycle behind the source
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n} <= sdram_pkg::cmd_deselect;
            dram_addr                                      <= '0;
        end else begin
            {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n} <= next_cmd;
            dram_addr                                      <= next_addr;
        end
    end

endmodule

// File: sdram_front.sv
`timescale 1ns/100ps

module sdram_front (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             start,      // Begin init
    input  logic                             cfg_write,
    input  logic [sdram_pkg::cfg_addr_w-1:0] cfg_addr,
    input  logic [sdram_pkg::cfg_data_w-1:0] cfg_data,
    output logic                             busy,
    output logic                             ready,
    output logic [sdram_pkg::addr_w-1:0]     dram_addr,
    output logic [sdram_pkg::ba_w-1:0]       dram_ba,
    output logic                             dram_cs_n,
    output logic                             dram_ras_n,
    output logic                             dram_cas_n,
    output logic                             dram_we_n
);

    logic [sdram_pkg::powerup_w-1:0] powerup_wait;
    logic [sdram_pkg::cas_w-1:0]     cas_latency;
    logic [sdram_pkg::burst_w-1:0]   burst_code;
    logic [sdram_pkg::refi_w-1:0]    refresh_interval;
    logic                            init_done;     // MRS cycle
    logic [3:0]                      init_cmd;
    logic [sdram_pkg::addr_w-1:0]    init_addr;
    logic [3:0]                      ref_cmd;

    sdram_cfg_regs sdram_cfg_regs_inst (
        .clock(clock), .reset(reset), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
        .cfg_data(cfg_data), .busy(busy), .powerup_wait(powerup_wait),
        .cas_latency(cas_latency), .burst_code(burst_code),
        .refresh_interval(refresh_interval)
    );

    sdram_init sdram_init_inst (
        .clock(clock), .reset(reset), .start(start), .powerup_wait(powerup_wait),
        .cas_latency(cas_latency), .burst_code(burst_code), .busy(busy),
        .init_done(init_done), .init_cmd(init_cmd), .init_addr(init_addr)
    );

    sdram_refresh sdram_refresh_inst (
        .clock(clock), .reset(reset), .init_done(init_done), .busy(busy),
        .refresh_interval(refresh_interval), .ready(ready), .ref_cmd(ref_cmd)
    );

    sdram_cmd_out sdram_cmd_out_inst (
        .clock(clock), .reset(reset), .busy(busy), .init_cmd(init_cmd),
        .init_addr(init_addr), .ref_cmd(ref_cmd), .dram_addr(dram_addr),
        .dram_ba(dram_ba), .dram_cs_n(dram_cs_n), .dram_ras_n(dram_ras_n),
        .dram_cas_n(dram_cas_n), .dram_we_n(dram_we_n)
    );

endmodule

// File: sdram_checker.sv
`timescale 1ns/100ps

module sdram_checker (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             start,
    input  logic                             cfg_write,
    input  logic [sdram_pkg::cfg_addr_w-1:0] cfg_addr,
    input  logic [sdram_pkg::cfg_data_w-1:0] cfg_data,
    input  logic                             busy,
    input  logic                             ready,
    input  logic [sdram_pkg::addr_w-1:0]     dram_addr,
    input  logic [sdram_pkg::ba_w-1:0]       dram_ba,
    input  logic                             dram_cs_n,
    input  logic                             dram_ras_n,
    input  logic                             dram_cas_n,
    input  logic                             dram_we_n,
    output int                               error_count,
    output int                               check_count,
    output int                               periodic_refreshes  // Since init finished
);

    localparam int idle_mode  = 0; // Waiting for start
    localparam int init_mode  = 1; // Replaying the bring-up stream
    localparam int ready_mode = 2; // Periodic refresh

    logic [18:0] expected_q[$];    // {ready, busy, addr, cmd} per clock
    int          mode = idle_mode;
    int          errors = 0;
    int          checks = 0;
    int          refreshes_done = 0;
    logic [14:0] powerup_wait;     // Model copy of the config registers
    logic [1:0]  cas_latency;
    logic [2:0]  burst_code;
    logic [11:0] refresh_interval;
    logic [11:0] refresh_gap;      // Cycles since MRS or last refresh
    logic [3:0]  exp_cmd;
    logic [12:0] exp_addr;
    logic        exp_busy;
    logic        exp_ready;
    logic [3:0]  pin_cmd;

    assign pin_cmd            = {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n};
    assign error_count        = errors;
    assign check_count        = checks;
    assign periodic_refreshes = refreshes_done;

    function automatic string cmd_name(input logic [3:0] cmd);
        case (cmd)
            sdram_pkg::cmd_nop:       return "NOP";
            sdram_pkg::cmd_precharge: return "PRECHARGE";
            sdram_pkg::cmd_refresh:   return "REFRESH";
            sdram_pkg::cmd_mrs:       return "MRS";
            sdram_pkg::cmd_deselect:  return "DESELECT";
            default:                  return "unknown";
        endcase
    endfunction

    task automatic compare(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %0t: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic push_step(input logic [3:0] cmd, input logic [12:0] addr,
                             input logic busy_v, input logic ready_v);
        expected_q.push_back({ready_v, busy_v, addr, cmd});
    endtask

    // Pin stream from the edge after start up to MRS
    task automatic build_init_stream();
        push_step(sdram_pkg::cmd_deselect, 13'h0000, 1'b1, 1'b0); // Pins one edge behind
        repeat (powerup_wait) push_step(sdram_pkg::cmd_nop, 13'h0000, 1'b1, 1'b0);
        push_step(sdram_pkg::cmd_precharge, 13'h0400, 1'b1, 1'b0); // A10 only
        repeat (sdram_pkg::trp_cycles) push_step(sdram_pkg::cmd_nop, 13'h0000, 1'b1, 1'b0);
        repeat (sdram_pkg::init_refreshes) begin
            push_step(sdram_pkg::cmd_refresh, 13'h0000, 1'b1, 1'b0);
            repeat (sdram_pkg::trc_cycles) push_step(sdram_pkg::cmd_nop, 13'h0000, 1'b1, 1'b0);
        end
        // Single-location writes, CAS in 5:4, burst in 2:0
        push_step(sdram_pkg::cmd_mrs, {3'b000, 1'b1, 3'b000, cas_latency, 1'b0, burst_code},
                  1'b0, 1'b1);
    endtask

    task automatic next_expected();
        exp_cmd   = sdram_pkg::cmd_nop;
        exp_addr  = '0;
        exp_busy  = 1'b0;
        exp_ready = 1'b0;
        case (mode)
            init_mode: begin
                {exp_ready, exp_busy, exp_addr, exp_cmd} = expected_q.pop_front();
                if (expected_q.size() == 0) begin
                    mode        = ready_mode;  // MRS on the pins now
                    refresh_gap = '0;
                end
            end
            ready_mode: begin
                exp_ready   = 1'b1;
                refresh_gap = refresh_gap + 12'd1;
                if (refresh_gap == refresh_interval) begin
                    exp_cmd     = sdram_pkg::cmd_refresh;
                    refresh_gap = '0;
                    refreshes_done++;
                end
            end
            default: exp_cmd = sdram_pkg::cmd_deselect;
        endcase
    endtask

    task automatic compare_pins();
        compare("{dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n}",
                16'(exp_cmd), 16'(pin_cmd));
        if (pin_cmd !== exp_cmd) begin
            if (exp_cmd == sdram_pkg::cmd_nop || exp_cmd == sdram_pkg::cmd_deselect)
                $display("%0t: unexpected %s command on the pins", $time, cmd_name(pin_cmd));
            else
                $display("%0t: %s command missing, pins show %s", $time, cmd_name(exp_cmd),
                         cmd_name(pin_cmd));
        end
        compare("dram_addr", 16'(exp_addr), 16'(dram_addr));
        compare("dram_ba", 16'h0000, 16'(dram_ba));     // Bank 0 always
        compare("busy", 16'(exp_busy), 16'(busy));
        compare("ready", 16'(exp_ready), 16'(ready));
    endtask

    task automatic take_config();
        case (cfg_addr)
            sdram_pkg::cfg_powerup: powerup_wait = cfg_data[sdram_pkg::powerup_w-1:0];
            sdram_pkg::cfg_mode: begin
                cas_latency = cfg_data[5:4];
                burst_code  = cfg_data[2:0];
            end
            sdram_pkg::cfg_refi: refresh_interval = cfg_data[sdram_pkg::refi_w-1:0];
            default: ;                                  // Unmapped address
        endcase
    endtask

    // Outputs read before this edge's updates land
    always @(posedge clock) begin
        if (reset) begin
            mode = idle_mode;
            expected_q.delete();
            powerup_wait     = sdram_pkg::powerup_default;
            cas_latency      = sdram_pkg::cas_default;
            burst_code       = sdram_pkg::burst_default;
            refresh_interval = sdram_pkg::refi_default;
            refreshes_done   = 0;
        end else begin
            next_expected();
            compare_pins();
            if (start && mode == idle_mode) begin
                build_init_stream();                    // Uses wait length at start
                mode = init_mode;
            end
            if (cfg_write && !exp_busy) take_config(); // Frozen during init
        end
    end

endmodule

// File: tb_sdram_front.sv
`timescale 1ns/100ps

module tb_sdram_front;

    localparam int runs = 3;

    logic                             clock;
    logic                             reset;
    logic                             start;
    logic                             cfg_write;
    logic [sdram_pkg::cfg_addr_w-1:0] cfg_addr;
    logic [sdram_pkg::cfg_data_w-1:0] cfg_data;
    logic                             busy;
    logic                             ready;
    logic [sdram_pkg::addr_w-1:0]     dram_addr;
    logic [sdram_pkg::ba_w-1:0]       dram_ba;
    logic                             dram_cs_n;
    logic                             dram_ras_n;
    logic                             dram_cas_n;
    logic                             dram_we_n;
    int                               error_count;
    int                               check_count;
    int                               periodic_refreshes;
    integer                           seed;
    int                               cycle_count = 0;
    int                               cycle_limit = 0;
    logic [15:0]                      powerup_run [runs];  // Per-run config
    logic [15:0]                      refi_run [runs];
    logic [1:0]                       cas_run [runs];
    logic [2:0]                       burst_run [runs];

    sdram_front sdram_front_inst (
        .clock(clock), .reset(reset), .start(start), .cfg_write(cfg_write),
        .cfg_addr(cfg_addr), .cfg_data(cfg_data), .busy(busy), .ready(ready),
        .dram_addr(dram_addr), .dram_ba(dram_ba), .dram_cs_n(dram_cs_n),
        .dram_ras_n(dram_ras_n), .dram_cas_n(dram_cas_n), .dram_we_n(dram_we_n)
    );

    sdram_checker sdram_checker_inst (
        .clock(clock), .reset(reset), .start(start), .cfg_write(cfg_write),
        .cfg_addr(cfg_addr), .cfg_data(cfg_data), .busy(busy), .ready(ready),
        .dram_addr(dram_addr), .dram_ba(dram_ba), .dram_cs_n(dram_cs_n),
        .dram_ras_n(dram_ras_n), .dram_cas_n(dram_cas_n), .dram_we_n(dram_we_n),
        .error_count(error_count), .check_count(check_count),
        .periodic_refreshes(periodic_refreshes)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;                      // 100 MHz sim clock
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, init or refreshes never finished", cycle_count);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic apply_reset();
        reset = 1'b1;
        repeat (4) @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic write_config(input logic [1:0] addr, input logic [15:0] data);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        @(negedge clock);
        cfg_write = 1'b0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    initial begin
        seed      = 32'h800d9cb2;
        reset     = 1'b1;
        start     = 1'b0;
        cfg_write = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;
        for (int i = 0; i < runs; i++) begin
            powerup_run[i] = 16'(20 + ($unsigned($random(seed)) % 101));
            refi_run[i]    = 16'(30 + ($unsigned($random(seed)) % 61));
            cas_run[i]     = 2'(2 + ($unsigned($random(seed)) % 2));
            burst_run[i]   = 3'($random(seed));
            cycle_limit    = cycle_limit + int'(powerup_run[i]) + 3
                             + sdram_pkg::init_refreshes * (sdram_pkg::trc_cycles + 1)
                             + 5 * int'(refi_run[i]);
        end
        cycle_limit = 3 * cycle_limit + 200;
        for (int i = 0; i < runs; i++) begin
            apply_reset();
            $display("Run %0d: powerup %0d, interval %0d, CAS %0d, burst %0d", i,
                     powerup_run[i], refi_run[i], cas_run[i], burst_run[i]);
            write_config(sdram_pkg::cfg_powerup, powerup_run[i]);
            write_config(sdram_pkg::cfg_mode, {10'd0, cas_run[i], 1'b0, burst_run[i]});
            write_config(sdram_pkg::cfg_refi, refi_run[i]);
            repeat (4) @(negedge clock);                // Idle, pins deselected
            pulse_start();
            repeat (3) @(negedge clock);
            write_config(sdram_pkg::cfg_powerup, 16'($random(seed))); // Dropped while busy
            write_config(sdram_pkg::cfg_mode, 16'($random(seed)));
            write_config(sdram_pkg::cfg_refi, 16'($random(seed)));
            while (!ready) @(negedge clock);
            while (periodic_refreshes < 4) @(negedge clock);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: sdram_front.f
sdram_pkg.sv
sdram_cfg_regs.sv
sdram_init.sv
sdram_refresh.sv
sdram_cmd_out.sv
sdram_front.sv
sdram_checker.sv
tb_sdram_front.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_sdram_front
FILELIST = sdram_front.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
